//--- stream_merge.f
+incdir+hw
hw/merge_pkg.sv
hw/shift_fifo.sv
hw/merge_arbiter.sv
hw/stream_merge_top.sv
tests/stream_merge_asserts.sv
tests/stream_merge_tb.sv

//--- Makefile
# Verilator build and run for the two-stream merge testbench

VERILATOR ?= verilator
TOP       ?= stream_merge_tb
FILELIST  ?= stream_merge.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(SIM): $(SRCS) $(FILELIST) hw/merge_settings.svh
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

test: $(SIM)
	./$(SIM) 2>&1 | tee $(LOG)
	@if grep -q "^CHECKS FAILED$$" $(LOG); then \
		echo "Result: FAIL"; exit 1; \
	elif ! grep -q "^ALL CHECKS PASSED$$" $(LOG); then \
		echo "Result: FAIL, run ended early"; exit 1; \
	else \
		echo "Result: PASS"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tests/stream_merge_tb.sv
/*
 * Testbench for the two-stream merge. Random pushes in three phases
 * (sparse, dense, stalled then drained), checked against per-source
 * scoreboard queues and a cycle model of the FIFO fill and pops.
 */
`timescale 1ns/1ps
`include "merge_settings.svh"

module stream_merge_tb;

   import merge_pkg::*;

   localparam int DEPTH = `MERGE_FIFO_DEPTH;

   logic                     clk;
   logic                     arst_n;
   logic [`MERGE_DATA_W-1:0] in_data_a;
   logic                     in_valid_a;
   logic [`MERGE_DATA_W-1:0] in_data_b;
   logic                     in_valid_b;
   logic                     out_stall;
   logic [`MERGE_DATA_W-1:0] out_data;
   src_e                     out_src;
   logic                     out_valid;
   logic                     err_a;
   logic                     err_b;

   logic [`MERGE_DATA_W-1:0] sb_a[$];    // Accepted words, oldest first
   logic [`MERGE_DATA_W-1:0] sb_b[$];
   int                       occ_a;      // Model fill levels
   int                       occ_b;
   logic                     fav_b;      // Model tie-break turn
   logic [1:0]               valid_pipe; // Model pops heading for out_valid
   logic                     exp_err_a;
   logic                     exp_err_b;
   int                       checks;
   int                       errors;
   int                       timeout;

   stream_merge_top UUT (
      .clk        (clk),
      .arst_n     (arst_n),
      .in_data_a  (in_data_a),
      .in_valid_a (in_valid_a),
      .in_data_b  (in_data_b),
      .in_valid_b (in_valid_b),
      .out_stall  (out_stall),
      .out_data   (out_data),
      .out_src    (out_src),
      .out_valid  (out_valid),
      .err_a      (err_a),
      .err_b      (err_b)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   task automatic report_mismatch(input string msg);
      $display("CHECK FAILED at time %0t: %s", $time, msg);
      errors++;
   endtask

   // Runs at the falling edge, where DUT outputs and TB inputs are both settled
   task automatic model_step();
      logic pop_a_m;
      logic pop_b_m;
      logic push_a_ok;
      logic push_b_ok;
      checks++;
      assert (out_valid == valid_pipe[1])
         else report_mismatch($sformatf("out_valid %0b, expected %0b", out_valid, valid_pipe[1]));
      assert (err_a == exp_err_a)
         else report_mismatch($sformatf("err_a %0b, expected %0b", err_a, exp_err_a));
      assert (err_b == exp_err_b)
         else report_mismatch($sformatf("err_b %0b, expected %0b", err_b, exp_err_b));
      if (out_valid && out_src == SRC_A) begin
         if (sb_a.size() == 0) begin
            report_mismatch("word tagged A with nothing pending on A");
         end else begin
            assert (out_data == sb_a[0])
               else report_mismatch($sformatf("A word %h, expected %h", out_data, sb_a[0]));
            void'(sb_a.pop_front());
         end
      end else if (out_valid) begin
         if (sb_b.size() == 0) begin
            report_mismatch("word tagged B with nothing pending on B");
         end else begin
            assert (out_data == sb_b[0])
               else report_mismatch($sformatf("B word %h, expected %h", out_data, sb_b[0]));
            void'(sb_b.pop_front());
         end
      end

      // Pop choice: the only non-empty one, else whichever is favored
      pop_a_m   = !out_stall && occ_a > 0 && (occ_b == 0 || !fav_b);
      pop_b_m   = !out_stall && occ_b > 0 && (occ_a == 0 || fav_b);
      push_a_ok = in_valid_a && (occ_a < DEPTH || pop_a_m);
      push_b_ok = in_valid_b && (occ_b < DEPTH || pop_b_m);
      exp_err_a = in_valid_a && occ_a == DEPTH && !pop_a_m;  // Dropped push
      exp_err_b = in_valid_b && occ_b == DEPTH && !pop_b_m;
      if (push_a_ok) sb_a.push_back(in_data_a);
      if (push_b_ok) sb_b.push_back(in_data_b);
      occ_a = occ_a + (push_a_ok ? 1 : 0) - (pop_a_m ? 1 : 0);
      occ_b = occ_b + (push_b_ok ? 1 : 0) - (pop_b_m ? 1 : 0);
      if (pop_a_m) fav_b = 1'b1;
      else if (pop_b_m) fav_b = 1'b0;
      valid_pipe = {valid_pipe[0], pop_a_m | pop_b_m};
   endtask

   task automatic drive_cycle(input logic push_a, input logic push_b, input logic stall);
      @(posedge clk);
      #5;
      in_valid_a = push_a;
      in_data_a  = {$urandom, $urandom};
      in_valid_b = push_b;
      in_data_b  = {$urandom, $urandom};
      out_stall  = stall;
      @(negedge clk);
      model_step();
   endtask

   initial begin
      void'($urandom(32'h744e72b2));
      arst_n     = 1'b0;
      in_data_a  = '0;
      in_valid_a = 1'b0;
      in_data_b  = '0;
      in_valid_b = 1'b0;
      out_stall  = 1'b0;
      occ_a      = 0;
      occ_b      = 0;
      fav_b      = 1'b0;
      valid_pipe = 2'b00;
      exp_err_a  = 1'b0;
      exp_err_b  = 1'b0;
      checks     = 0;
      errors     = 0;
      repeat (8) @(posedge clk);
      #5 arst_n = 1'b1;
      @(negedge clk);
      checks++;
      assert (!out_valid && !err_a && !err_b)
         else report_mismatch("out_valid or err high after reset");

      repeat (200) drive_cycle(($urandom % 5) == 0, ($urandom % 5) == 0, 1'b0);  // Sparse
      repeat (200) drive_cycle(($urandom % 8) != 0, ($urandom % 8) != 0, 1'b0);  // Dense
      repeat (30) drive_cycle(($urandom % 2) == 0, ($urandom % 2) == 0, 1'b1);   // Stalled

      // Drain after release
      timeout = 0;
      while ((sb_a.size() > 0 || sb_b.size() > 0) && timeout < 100) begin
         drive_cycle(1'b0, 1'b0, 1'b0);
         timeout++;
      end
      if (sb_a.size() > 0 || sb_b.size() > 0) begin
         $display("Timeout: %0d words of A and %0d of B never came out after the stall",
                  sb_a.size(), sb_b.size());
         $display("Checks: %0d, errors: %0d", checks, errors);
         $display("CHECKS FAILED");
      end else begin
         repeat (4) drive_cycle(1'b0, 1'b0, 1'b0);   // Nothing stray may follow
         $display("Checks: %0d, errors: %0d", checks, errors);
         if (errors == 0) begin
            $display("ALL CHECKS PASSED");
         end else begin
            $display("CHECKS FAILED");
         end
      end
      $finish;
   end

endmodule

//--- tests/stream_merge_asserts.sv
/*
 * Concurrent checks on the merge's pop strobes, FIFO flags and errors.
 * Bound into stream_merge_top so internal FIFO-to-arbiter wires are visible.
 */
`timescale 1ns/1ps

module stream_merge_asserts (
   input logic clk,
   input logic arst_n,
   input logic in_valid_a,
   input logic in_valid_b,
   input logic out_stall,
   input logic out_valid,
   input logic pop_a,
   input logic pop_b,
   input logic empty_a,
   input logic empty_b,
   input logic full_a,
   input logic full_b,
   input logic err_a,
   input logic err_b
);

   // At most one pop per clock
   one_pop: assert property (@(posedge clk) disable iff (!arst_n) !(pop_a && pop_b))
      else $error("pop_a and pop_b high in the same cycle");

   no_pop_empty_a: assert property (@(posedge clk) disable iff (!arst_n) pop_a |-> !empty_a)
      else $error("pop_a issued while FIFO A is empty");

   no_pop_empty_b: assert property (@(posedge clk) disable iff (!arst_n) pop_b |-> !empty_b)
      else $error("pop_b issued while FIFO B is empty");

   // B cannot drain without a pop, so the turn must pass to it
   alternate_ab: assert property (@(posedge clk) disable iff (!arst_n)
      (pop_a && !empty_b) |=> (out_stall || pop_b))
      else $error("B not popped after A while both held data");

   alternate_ba: assert property (@(posedge clk) disable iff (!arst_n)
      (pop_b && !empty_a) |=> (out_stall || pop_a))
      else $error("A not popped after B while both held data");

   overflow_a: assert property (@(posedge clk) disable iff (!arst_n)
      (in_valid_a && full_a && !pop_a) |=> err_a)
      else $error("push into full FIFO A without err_a");

   overflow_b: assert property (@(posedge clk) disable iff (!arst_n)
      (in_valid_b && full_b && !pop_b) |=> err_b)
      else $error("push into full FIFO B without err_b");

   stall_no_pop: assert property (@(posedge clk) disable iff (!arst_n)
      out_stall |-> !(pop_a || pop_b))
      else $error("pop issued while out_stall high");

   // Two words may still be in flight, none after that
   stall_quiet: assert property (@(posedge clk) disable iff (!arst_n)
      (out_stall && $past(out_stall) && $past(out_stall, 2)) |-> !out_valid)
      else $error("out_valid more than 2 cycles into a stall");

endmodule

bind stream_merge_top stream_merge_asserts u_asserts (
   .clk        (clk),
   .arst_n     (arst_n),
   .in_valid_a (in_valid_a),
   .in_valid_b (in_valid_b),
   .out_stall  (out_stall),
   .out_valid  (out_valid),
   .pop_a      (pop_a),
   .pop_b      (pop_b),
   .empty_a    (empty_a),
   .empty_b    (empty_b),
   .full_a     (full_a),
   .full_b     (full_b),
   .err_a      (err_a),
   .err_b      (err_b)
);

//--- hw/stream_merge_top.sv
/*
 * Two-stream merge: one shift FIFO per input stream feeding the
 * alternating arbiter. Push to out_valid is 3 cycles when uncontended.
 */
`timescale 1ns/1ps
`include "merge_settings.svh"

module stream_merge_top (
   input  logic                     clk,
   input  logic                     arst_n,
   input  logic [`MERGE_DATA_W-1:0] in_data_a,
   input  logic                     in_valid_a,
   input  logic [`MERGE_DATA_W-1:0] in_data_b,
   input  logic                     in_valid_b,
   input  logic                     out_stall,
   output logic [`MERGE_DATA_W-1:0] out_data,
   output merge_pkg::src_e          out_src,
   output logic                     out_valid,
   output logic                     err_a,
   output logic                     err_b
);

   logic [`MERGE_DATA_W-1:0] data_a;
   logic [`MERGE_DATA_W-1:0] data_b;
   logic                     data_valid_a;
   logic                     data_valid_b;
   logic                     empty_a;
   logic                     empty_b;
   logic                     full_a;     // Status only, overflow shows on err_a
   logic                     full_b;
   logic                     pop_a;
   logic                     pop_b;

   shift_fifo fifo_a (
      .clk            (clk),
      .arst_n         (arst_n),
      .data_in        (in_data_a),
      .data_in_valid  (in_valid_a),
      .pop_fifo       (pop_a),
      .data_out       (data_a),
      .data_out_valid (data_valid_a),
      .fifo_empty     (empty_a),
      .fifo_full      (full_a),
      .err            (err_a)
   );

   shift_fifo fifo_b (
      .clk            (clk),
      .arst_n         (arst_n),
      .data_in        (in_data_b),
      .data_in_valid  (in_valid_b),
      .pop_fifo       (pop_b),
      .data_out       (data_b),
      .data_out_valid (data_valid_b),
      .fifo_empty     (empty_b),
      .fifo_full      (full_b),
      .err            (err_b)
   );

   merge_arbiter arb (
      .clk          (clk),
      .arst_n       (arst_n),
      .out_stall    (out_stall),
      .empty_a      (empty_a),
      .empty_b      (empty_b),
      .data_a       (data_a),
      .data_b       (data_b),
      .data_valid_a (data_valid_a),
      .data_valid_b (data_valid_b),
      .pop_a        (pop_a),
      .pop_b        (pop_b),
      .out_data     (out_data),
      .out_src      (out_src),
      .out_valid    (out_valid)
   );

endmodule

//--- hw/merge_arbiter.sv
/*
 * Pops at most one of two FIFOs per clock, taking turns when both hold
 * data, and registers the returning word with its source tag.
 * Pops stop while out_stall is high; words already popped still emerge.
 */
`timescale 1ns/1ps
`include "merge_settings.svh"

module merge_arbiter (
   input  logic                     clk,
   input  logic                     arst_n,
   input  logic                     out_stall,
   input  logic                     empty_a,
   input  logic                     empty_b,
   input  logic [`MERGE_DATA_W-1:0] data_a,
   input  logic [`MERGE_DATA_W-1:0] data_b,
   input  logic                     data_valid_a,
   input  logic                     data_valid_b,
   output logic                     pop_a,
   output logic                     pop_b,
   output logic [`MERGE_DATA_W-1:0] out_data,
   output merge_pkg::src_e          out_src,
   output logic                     out_valid
);

   import merge_pkg::*;

   arb_state_e state;           // Stream favored on the next tie

   // Empty flags already reflect last cycle's pop, so back-to-back pops are safe
   assign pop_a = ~out_stall & ~empty_a & (empty_b | (state == GRANT_A));
   assign pop_b = ~out_stall & ~empty_b & (empty_a | (state == GRANT_B));

   // Favor the other stream after each pop
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state <= GRANT_A;
      end else if (pop_a) begin
         state <= GRANT_B;
      end else if (pop_b) begin
         state <= GRANT_A;
      end
   end

   // Output stage; at most one FIFO returns a word per cycle
   always_ff @(posedge clk) begin
      if (data_valid_a) begin
         out_data <= data_a;
         out_src  <= SRC_A;
      end else if (data_valid_b) begin
         out_data <= data_b;
         out_src  <= SRC_B;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         out_valid <= 1'b0;
      end else begin
         out_valid <= data_valid_a | data_valid_b;
      end
   end

endmodule

//--- hw/shift_fifo.sv
/*
 * Shift-register FIFO with one-hot occupancy. Words enter at slot 0 and
 * move up on each push; a pop registers the oldest word into data_out.
 * err pulses for one cycle on overflow or underflow.
 */
`timescale 1ns/1ps
`include "merge_settings.svh"

module shift_fifo (
   input  logic                     clk,
   input  logic                     arst_n,
   input  logic [`MERGE_DATA_W-1:0] data_in,
   input  logic                     data_in_valid,
   input  logic                     pop_fifo,
   output logic [`MERGE_DATA_W-1:0] data_out,
   output logic                     data_out_valid,
   output logic                     fifo_empty,
   output logic                     fifo_full,
   output logic                     err
);

   localparam int W     = `MERGE_DATA_W;
   localparam int DEPTH = `MERGE_FIFO_DEPTH;

   logic [W-1:0]   q [DEPTH];    // Slot 0 is the newest word
   logic [DEPTH:0] occ;          // One-hot fill level
   logic [DEPTH:0] occ_next;
   logic [W-1:0]   oldest;       // Word a pop would take now
   logic           push_ok;
   logic           pop_ok;
   logic           err_next;

   assign fifo_empty = occ[0];
   assign fifo_full  = occ[DEPTH];

   // Pop only counts with something stored
   assign pop_ok  = pop_fifo & ~fifo_empty;
   // Full FIFO still takes a push if a pop frees a slot
   assign push_ok = data_in_valid & (~fifo_full | pop_ok);

   // Overflow without a pop, or underflow
   assign err_next = (data_in_valid & fifo_full & ~pop_fifo) |
                     (pop_fifo & fifo_empty);

   // With n entries the oldest sits in slot n-1
   always_comb begin
      oldest = q[0];
      for (int i = 1; i <= DEPTH; i++) begin
         if (occ[i]) begin
            oldest = q[i-1];
         end
      end
   end

   always_comb begin
      occ_next = occ;                       // Hold, or push and pop together
      if (push_ok && !pop_ok) begin
         occ_next = occ << 1;
      end else if (pop_ok && !push_ok) begin
         occ_next = occ >> 1;
      end
   end

   // Fill level
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         occ <= {{DEPTH{1'b0}}, 1'b1};      // Empty
      end else begin
         occ <= occ_next;
      end
   end

   // Storage shifts up by one on every accepted push
   always_ff @(posedge clk) begin
      if (push_ok) begin
         q[0] <= data_in;
         for (int i = 1; i < DEPTH; i++) begin
            q[i] <= q[i-1];
         end
      end
   end

   // Output word, taken before any same-cycle push lands
   always_ff @(posedge clk) begin
      if (pop_ok) begin
         data_out <= oldest;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         data_out_valid <= 1'b0;
         err            <= 1'b0;
      end else begin
         data_out_valid <= pop_ok;           // One cycle after the pop
         err            <= err_next;
      end
   end

endmodule

//--- hw/merge_pkg.sv
/*
 * Types shared by the merge arbiter and the top level.
 * Referenced by scoped name in port lists, imported inside module bodies.
 */
package merge_pkg;

   // Which stream wins the next tie
   typedef enum logic {
      GRANT_A = 1'b0,
      GRANT_B = 1'b1
   } arb_state_e;

   // Source tag carried with every merged word
   typedef enum logic {
      SRC_A = 1'b0,
      SRC_B = 1'b1
   } src_e;

endpackage

//--- hw/merge_settings.svh
/*
 * Build-time sizes for the two-stream merge.
 * Include wherever the word width or FIFO depth is needed.
 */
`ifndef MERGE_SETTINGS_SVH
`define MERGE_SETTINGS_SVH

// Width of one stream word
`define MERGE_DATA_W 64

// Entries per shift FIFO, kept small since occupancy is one-hot
`define MERGE_FIFO_DEPTH 4

`endif
